// File: Bender.yml
package:
  name: uart_rx

sources:
  # rtl in compile order
  - source/uart_rx_pkg.sv
  - source/baud_gen.sv
  - source/rx_framer.sv
  - source/msg_buffer.sv
  - source/uart_rx_top.sv
  # testbench and bound checker
  - target: test
    files:
      - tb/uart_rx_chk.sv
      - tb/uart_rx_tb.sv

// File: source/baud_gen.sv
`timescale 1ns/1ps

module baud_gen #(
  parameter int CLK_DIV = 434
) (
  input  logic clk,
  input  logic nrst,
  input  logic restart,
  output logic tick
);

  localparam int CNT_W = (CLK_DIV > 2) ? $clog2(CLK_DIV) : 1;
  localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(CLK_DIV - 1);
  localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'(CLK_DIV / 2 - 1);

  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_next;
  logic             cnt_zero;

  assign cnt_zero = (cnt == '0);

  // restart lines the first tick up with the middle of the start bit.
  always_comb begin
    if (restart) begin
      cnt_next = HALF_LOAD;
    end else if (cnt_zero) begin
      cnt_next = FULL_LOAD;
    end else begin
      cnt_next = cnt - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      cnt  <= FULL_LOAD;
      tick <= 1'b0;
    end else begin
      cnt  <= cnt_next;
      tick <= cnt_zero && !restart;
    end
  end

endmodule

// File: source/msg_buffer.sv
`timescale 1ns/1ps

module msg_buffer #(
  parameter int MSG_BYTES = 16
) (
  input  logic                                        clk,
  input  logic                                        nrst,
  input  logic [uart_rx_pkg::DATA_BITS-1:0]           byte_data,
  input  logic                                        byte_valid,
  input  logic                                        msg_clear,
  output logic [MSG_BYTES*uart_rx_pkg::DATA_BITS-1:0] msg,
  output logic [$clog2(MSG_BYTES+1)-1:0]              msg_count,
  output logic                                        msg_full
);

  localparam int MSG_W = MSG_BYTES * uart_rx_pkg::DATA_BITS;
  localparam int CNT_W = $clog2(MSG_BYTES + 1);
  localparam logic [CNT_W-1:0] CAPACITY = CNT_W'(MSG_BYTES);

  logic store;

  assign msg_full = (msg_count == CAPACITY);
  assign store    = byte_valid && !msg_full;

  // clear wins over a byte in the same cycle.
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      msg       <= '0;
      msg_count <= '0;
    end else if (msg_clear) begin
      msg       <= '0;
      msg_count <= '0;
    end else if (store) begin
      // newest byte lands in the low byte.
      msg       <= (msg << uart_rx_pkg::DATA_BITS) | MSG_W'(byte_data);
      msg_count <= msg_count + 1'b1;
    end
  end

endmodule

// File: source/rx_framer.sv
`timescale 1ns/1ps

module rx_framer (
  input  logic                                clk,
  input  logic                                nrst,
  input  logic                                rx,
  input  logic                                tick,
  output logic                                restart,
  output logic [uart_rx_pkg::DATA_BITS-1:0]   byte_data,
  output logic                                byte_valid,
  output logic                                frame_error,
  output logic                                busy
);

  localparam int BIT_W = (uart_rx_pkg::DATA_BITS > 2) ? $clog2(uart_rx_pkg::DATA_BITS) : 1;
  localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(uart_rx_pkg::DATA_BITS - 1);

  uart_rx_pkg::rx_state_e state;
  uart_rx_pkg::rx_state_e state_next;

  logic                              rx_meta;
  logic                              rx_sync;
  logic                              rx_prev;
  logic                              start_edge;
  logic                              sample;
  logic [BIT_W-1:0]                  bit_cnt;
  logic [uart_rx_pkg::DATA_BITS-1:0] shift_reg;

  // two-flop synchronizer, idle line is high.
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = (state == uart_rx_pkg::IDLE) && rx_prev && !rx_sync;

  // a tick from before the divider reloads is stale.
  assign sample = tick && !restart;

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      restart <= 1'b0;
    end else begin
      restart <= start_edge;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      uart_rx_pkg::IDLE: begin
        if (start_edge) begin
          state_next = uart_rx_pkg::START;
        end
      end
      uart_rx_pkg::START: begin
        // high again at mid-bit means a false start.
        if (sample) begin
          state_next = rx_sync ? uart_rx_pkg::IDLE : uart_rx_pkg::DATA;
        end
      end
      uart_rx_pkg::DATA: begin
        if (sample && (bit_cnt == LAST_BIT)) begin
          state_next = uart_rx_pkg::STOP;
        end
      end
      uart_rx_pkg::STOP: begin
        if (sample) begin
          state_next = uart_rx_pkg::IDLE;
        end
      end
      default: begin
        state_next = uart_rx_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      state <= uart_rx_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      bit_cnt <= '0;
    end else if (state != uart_rx_pkg::DATA) begin
      bit_cnt <= '0;
    end else if (sample) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // lsb arrives first, so shift in from the top.
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      shift_reg <= '0;
    end else if ((state == uart_rx_pkg::DATA) && sample) begin
      shift_reg <= {rx_sync, shift_reg[uart_rx_pkg::DATA_BITS-1:1]};
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      byte_data   <= '0;
      byte_valid  <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      byte_valid  <= 1'b0;
      frame_error <= 1'b0;
      if ((state == uart_rx_pkg::STOP) && sample) begin
        if (rx_sync) begin
          byte_data  <= shift_reg;
          byte_valid <= 1'b1;
        end else begin
          frame_error <= 1'b1;
        end
      end
    end
  end

  assign busy = (state != uart_rx_pkg::IDLE);

endmodule

// File: source/uart_rx_pkg.sv
package uart_rx_pkg;

  // data bits per frame, sent lsb first.
  localparam int DATA_BITS = 8;

  // framer states, one per part of the frame.
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } rx_state_e;

endpackage

// File: source/uart_rx_top.sv
`timescale 1ns/1ps

module uart_rx_top #(
  parameter int CLK_DIV   = 434,
  parameter int MSG_BYTES = 16
) (
  input  logic                                        clk,
  input  logic                                        nrst,
  input  logic                                        rx,
  input  logic                                        msg_clear,
  output logic [uart_rx_pkg::DATA_BITS-1:0]           data,
  output logic                                        data_valid,
  output logic                                        frame_error,
  output logic                                        busy,
  output logic [MSG_BYTES*uart_rx_pkg::DATA_BITS-1:0] msg,
  output logic [$clog2(MSG_BYTES+1)-1:0]              msg_count,
  output logic                                        msg_full
);

  logic restart;
  logic tick;

  baud_gen #(
    .CLK_DIV (CLK_DIV)
  ) u_baud_gen (
    .clk     (clk),
    .nrst    (nrst),
    .restart (restart),
    .tick    (tick)
  );

  rx_framer u_rx_framer (
    .clk         (clk),
    .nrst        (nrst),
    .rx          (rx),
    .tick        (tick),
    .restart     (restart),
    .byte_data   (data),
    .byte_valid  (data_valid),
    .frame_error (frame_error),
    .busy        (busy)
  );

  // good bytes also collect in the message register.
  msg_buffer #(
    .MSG_BYTES (MSG_BYTES)
  ) u_msg_buffer (
    .clk        (clk),
    .nrst       (nrst),
    .byte_data  (data),
    .byte_valid (data_valid),
    .msg_clear  (msg_clear),
    .msg        (msg),
    .msg_count  (msg_count),
    .msg_full   (msg_full)
  );

endmodule

// File: tb/uart_rx_chk.sv
`timescale 1ns/1ps

module uart_rx_chk #(
  parameter int MSG_BYTES = 16
) (
  input logic                           clk,
  input logic                           nrst,
  input logic                           data_valid,
  input logic                           frame_error,
  input logic                           busy,
  input logic                           msg_clear,
  input logic [$clog2(MSG_BYTES+1)-1:0] msg_count,
  input logic                           msg_full
);

  // a frame ends either good or bad, never both.
  a_outcome_excl: assert property (@(posedge clk) disable iff (!nrst)
    !(data_valid && frame_error))
    else $error("data_valid and frame_error high together");

  a_valid_pulse: assert property (@(posedge clk) disable iff (!nrst)
    data_valid |=> !data_valid)
    else $error("data_valid longer than one cycle");

  a_error_pulse: assert property (@(posedge clk) disable iff (!nrst)
    frame_error |=> !frame_error)
    else $error("frame_error longer than one cycle");

  a_count_range: assert property (@(posedge clk) disable iff (!nrst)
    msg_count <= MSG_BYTES)
    else $error("msg_count above capacity");

  // once full, only a clear lets the count move.
  a_full_hold: assert property (@(posedge clk) disable iff (!nrst)
    msg_full && !msg_clear |=> msg_full && $stable(msg_count))
    else $error("msg_full dropped or msg_count moved without msg_clear");

  a_busy_reset: assert property (@(posedge clk) !nrst |-> !busy)
    else $error("busy high during reset");

endmodule

bind uart_rx_top uart_rx_chk #(
  .MSG_BYTES (MSG_BYTES)
) u_uart_rx_chk (
  .clk         (clk),
  .nrst        (nrst),
  .data_valid  (data_valid),
  .frame_error (frame_error),
  .busy        (busy),
  .msg_clear   (msg_clear),
  .msg_count   (msg_count),
  .msg_full    (msg_full)
);

// File: tb/uart_rx_tb.sv
`timescale 1ns/1ps

module uart_rx_tb;

  localparam int CLK_DIV       = 16;
  localparam int MSG_BYTES     = 4;
  localparam int MSG_W         = MSG_BYTES * 8;
  localparam int CNT_W         = $clog2(MSG_BYTES + 1);
  localparam int FRAME_TIMEOUT = 12 * CLK_DIV;
  localparam int QUIET_WINDOW  = 3 * CLK_DIV;

  localparam logic [1:0] OUT_GOOD  = 2'd0;
  localparam logic [1:0] OUT_ERROR = 2'd1;
  localparam logic [1:0] OUT_NONE  = 2'd2;

  typedef struct packed {
    logic [7:0] data;
    logic       stop_bit;
    logic       glitch;
    logic       clear;
    logic [1:0] kind;
  } entry_t;

  logic             clk;
  logic             nrst;
  logic             rx;
  logic             msg_clear;
  logic [7:0]       data;
  logic             data_valid;
  logic             frame_error;
  logic             busy;
  logic [MSG_W-1:0] msg;
  logic [CNT_W-1:0] msg_count;
  logic             msg_full;

  entry_t           entries[$];
  logic [31:0]      lcg_state;
  int               errors;
  int               checks;
  logic             got_valid;
  logic             got_error;
  logic             timed_out;
  logic [7:0]       got_data;
  logic [MSG_W-1:0] model_msg;
  int               model_count;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  uart_rx_top #(
    .CLK_DIV   (CLK_DIV),
    .MSG_BYTES (MSG_BYTES)
  ) u_uart_rx_top (
    .clk         (clk),
    .nrst        (nrst),
    .rx          (rx),
    .msg_clear   (msg_clear),
    .data        (data),
    .data_valid  (data_valid),
    .frame_error (frame_error),
    .busy        (busy),
    .msg         (msg),
    .msg_count   (msg_count),
    .msg_full    (msg_full)
  );

  function automatic logic [7:0] lcg_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic add_entry(input logic [7:0] b, input logic use_rand, input logic stop_bit,
                           input logic glitch, input logic clear, input logic [1:0] kind);
    entry_t e;
    e.data     = use_rand ? lcg_byte() : b;
    e.stop_bit = stop_bit;
    e.glitch   = glitch;
    e.clear    = clear;
    e.kind     = kind;
    entries.push_back(e);
  endtask

  // the message fills after entry 5, entries 6 and 7 overflow it.
  task automatic build_table();
    add_entry(8'h55, 1'b0, 1'b1, 1'b0, 1'b0, OUT_GOOD);
    add_entry(8'ha3, 1'b0, 1'b1, 1'b0, 1'b0, OUT_GOOD);
    add_entry(8'h00, 1'b1, 1'b1, 1'b0, 1'b0, OUT_GOOD);
    add_entry(8'h00, 1'b0, 1'b0, 1'b0, 1'b0, OUT_ERROR);
    add_entry(8'h00, 1'b0, 1'b1, 1'b1, 1'b0, OUT_NONE);
    add_entry(8'hff, 1'b0, 1'b1, 1'b0, 1'b0, OUT_GOOD);
    add_entry(8'h00, 1'b1, 1'b1, 1'b0, 1'b0, OUT_GOOD);
    add_entry(8'h81, 1'b0, 1'b1, 1'b0, 1'b0, OUT_GOOD);
    add_entry(8'h3c, 1'b0, 1'b1, 1'b0, 1'b1, OUT_GOOD);
    add_entry(8'h00, 1'b1, 1'b1, 1'b0, 1'b0, OUT_GOOD);
    add_entry(8'h00, 1'b1, 1'b0, 1'b0, 1'b0, OUT_ERROR);
    add_entry(8'h00, 1'b0, 1'b1, 1'b1, 1'b0, OUT_NONE);
    add_entry(8'hc5, 1'b0, 1'b1, 1'b0, 1'b0, OUT_GOOD);
  endtask

  // start bit, eight data bits lsb first, then the stop bit.
  task automatic send_frame(input logic [7:0] b, input logic stop_bit, input logic glitch);
    int i;
    if (glitch) begin
      rx <= 1'b0;
      repeat (CLK_DIV / 4) @(posedge clk);
      rx <= 1'b1;
    end else begin
      rx <= 1'b0;
      repeat (CLK_DIV) @(posedge clk);
      for (i = 0; i < 8; i++) begin
        rx <= b[i];
        repeat (CLK_DIV) @(posedge clk);
      end
      rx <= stop_bit;
      repeat (CLK_DIV) @(posedge clk);
    end
  endtask

  task automatic wait_outcome(input int limit);
    int n;
    got_valid = 1'b0;
    got_error = 1'b0;
    got_data  = '0;
    timed_out = 1'b1;
    for (n = 0; n < limit; n++) begin
      @(posedge clk);
      if (data_valid || frame_error) begin
        got_valid = data_valid;
        got_error = frame_error;
        got_data  = data;
        timed_out = 1'b0;
        break;
      end
    end
  endtask

  task automatic check_msg();
    check("msg", model_msg, msg);
    check("msg_count", model_count, msg_count);
    check("msg_full", model_count == MSG_BYTES, msg_full);
  endtask

  task automatic clear_msg();
    msg_clear <= 1'b1;
    @(posedge clk);
    msg_clear <= 1'b0;
    @(posedge clk);
    model_msg   = '0;
    model_count = 0;
    check_msg();
  endtask

  initial begin
    int     idx;
    entry_t e;
    errors      = 0;
    checks      = 0;
    nrst        = 1'b0;
    rx          = 1'b1;
    msg_clear   = 1'b0;
    lcg_state   = 32'd51850;
    model_msg   = '0;
    model_count = 0;
    build_table();
    repeat (8) @(posedge clk);
    nrst <= 1'b1;
    repeat (2) @(posedge clk);
    check("data_valid", 0, data_valid);
    check("frame_error", 0, frame_error);
    check("busy", 0, busy);
    check("data", 0, data);
    check_msg();

    for (idx = 0; idx < entries.size(); idx++) begin
      e = entries[idx];
      if (e.clear) begin
        clear_msg();
      end
      // good frames follow each other with no idle gap.
      fork
        send_frame(e.data, e.stop_bit, e.glitch);
        wait_outcome(e.kind == OUT_NONE ? QUIET_WINDOW : FRAME_TIMEOUT);
      join
      if (e.kind == OUT_NONE) begin
        if (!timed_out) begin
          errors++;
          $display("entry %0d: a short glitch was taken as a frame", idx);
        end
        check("busy", 0, busy);
      end else if (timed_out) begin
        errors++;
        $display("entry %0d: no data_valid or frame_error within %0d cycles",
                 idx, FRAME_TIMEOUT);
      end else if (e.kind == OUT_GOOD) begin
        check("data_valid", 1, got_valid);
        check("frame_error", 0, got_error);
        check("data", e.data, got_data);
        if (model_count < MSG_BYTES) begin
          model_msg = {model_msg[MSG_W-9:0], e.data};
          model_count++;
        end
      end else begin
        check("frame_error", 1, got_error);
        check("data_valid", 0, got_valid);
      end
      check_msg();
      // a low stop bit leaves the line low, so idle it before the next start.
      if (!e.stop_bit && !e.glitch) begin
        rx <= 1'b1;
        repeat (CLK_DIV) @(posedge clk);
      end
    end

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: uart_rx_top.f
source/uart_rx_pkg.sv
source/baud_gen.sv
source/rx_framer.sv
source/msg_buffer.sv
source/uart_rx_top.sv
tb/uart_rx_chk.sv
tb/uart_rx_tb.sv
